//--- logic/isaPkg.sv
`default_nettype none

package isaPkg;

   localparam int dataW = 16;   // Data path width
   localparam int opW   = 5;    // Opcode field
   localparam int shOpW = 2;    // Shifter mode

   // Opcode numbering of the instruction set
   typedef enum logic [opW-1:0] {
      ADD  = 5'd0,
      SUB  = 5'd1,
      OR   = 5'd2,
      AND  = 5'd3,
      ROL  = 5'd4,
      SLL  = 5'd5,
      ROR  = 5'd6,
      SRA  = 5'd7,
      ST   = 5'd8,
      LD   = 5'd9,
      STU  = 5'd10,
      BTR  = 5'd11,
      SEQ  = 5'd12,
      SLT  = 5'd13,
      SLE  = 5'd14,
      SCO  = 5'd15,
      BEQZ = 5'd16,
      BNEZ = 5'd17,
      BLTZ = 5'd18,
      LBI  = 5'd19,
      SLBI = 5'd20,
      J    = 5'd21,
      JAL  = 5'd22,
      JR   = 5'd23,
      JALR = 5'd24,
      RET  = 5'd25,
      SIIC = 5'd26,
      RTI  = 5'd27,
      NOP  = 5'd28,
      HALT = 5'd29
   } aluOp_e;

   typedef enum logic [shOpW-1:0] {
      SH_ROL = 2'd0,
      SH_SLL = 2'd1,
      SH_ROR = 2'd2,
      SH_SRA = 2'd3   // Sign fill
   } shiftOp_e;

endpackage

`default_nettype wire

//--- logic/execPkg.sv
`default_nettype none

package execPkg;

   import isaPkg::*;

   // Decoded instruction into the stage
   typedef struct packed {
      aluOp_e           op;
      logic             sign;   // Signed overflow and compare
      logic [dataW-1:0] a;      // rs
      logic [dataW-1:0] b;      // rt or sign-extended immediate
      logic [dataW-1:0] pc;
   } execReq_t;

   // Registered stage output
   typedef struct packed {
      logic [dataW-1:0] result;
      logic             ofl;
      logic             zero;
      logic             redirect;  // Fetch must restart at target
      logic [dataW-1:0] target;
   } execResp_t;

endpackage

`default_nettype wire

//--- logic/add16.sv
`timescale 1ns/10ps
`default_nettype none

module add16 import isaPkg::*; (
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  logic             ci,
   output logic [dataW-1:0] sum,
   output logic             co,
   output logic             pGroup,
   output logic             gGroup
);

   logic [dataW-1:0] p;    // Bit propagate
   logic [dataW-1:0] g;    // Bit generate
   logic [dataW-1:0] c;    // Carry into each bit
   logic [3:0]       gp;   // Group propagate
   logic [3:0]       gg;   // Group generate
   logic [4:0]       gc;   // Carry into each group

   assign p = a ^ b;
   assign g = a & b;

   // First level, one 4-bit group at a time
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         gp[k] = &p[4*k +: 4];
         gg[k] = g[4*k+3]
               | (p[4*k+3] & g[4*k+2])
               | (p[4*k+3] & p[4*k+2] & g[4*k+1])
               | (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
      end
   end

   // Second level lookahead across groups
   assign gc[0] = ci;
   assign gc[1] = gg[0] | (gp[0] & ci);
   assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & ci);
   assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                | (gp[2] & gp[1] & gp[0] & ci);
   assign gGroup = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                 | (gp[3] & gp[2] & gp[1] & gg[0]);
   assign pGroup = &gp;
   assign gc[4]  = gGroup | (pGroup & ci);

   // Carries inside each group start from the group carry
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         c[4*k] = gc[k];
         for (int j = 1; j < 4; j++)
            c[4*k+j] = g[4*k+j-1] | (p[4*k+j-1] & c[4*k+j-1]);
      end
   end

   assign sum = p ^ c;
   assign co  = gc[4];

endmodule

`default_nettype wire

//--- logic/shift16.sv
`timescale 1ns/10ps
`default_nettype none

module shift16 import isaPkg::*; (
   input  logic [dataW-1:0] in,
   input  logic [3:0]       cnt,
   input  shiftOp_e         mode,
   output logic [dataW-1:0] out
);

   logic [dataW-1:0] stg [5];   // Stage outputs, stg[0] is the input

   // One log stage with a fixed shift amount
   function automatic logic [dataW-1:0] stage(input logic [dataW-1:0] v,
                                              input int unsigned n,
                                              input shiftOp_e m);
      logic [dataW-1:0] r;
      case (m)
         SH_ROL:  r = (v << n) | (v >> (dataW - n));
         SH_SLL:  r = v << n;
         SH_ROR:  r = (v >> n) | (v << (dataW - n));
         default: r = $signed(v) >>> n;   // Vacated bits take the sign
      endcase
      return r;
   endfunction

   always_comb begin
      stg[0] = in;
      for (int k = 0; k < 4; k++)
         stg[k+1] = cnt[k] ? stage(stg[k], 1 << k, mode) : stg[k];
   end

   assign out = stg[4];

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import isaPkg::*; (
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  aluOp_e           op,
   input  logic             sign,
   output logic [dataW-1:0] result,
   output logic [dataW-1:0] sum,
   output logic             ofl,
   output logic             zero
);

   logic [dataW-1:0] opA;
   logic [dataW-1:0] opB;
   logic             cin;
   logic             co;
   logic             isSub;
   logic             sumOp;       // Opcodes whose result is the adder sum
   logic             oflSigned;
   shiftOp_e         shMode;
   logic [dataW-1:0] shOut;
   logic [dataW-1:0] btrOut;
   logic             eq;
   logic             lt;

   // SUB is rt - rs, so rs goes in inverted
   assign isSub = (op == SUB);
   assign opA   = isSub ? b : a;
   assign opB   = isSub ? ~a : b;
   assign cin   = isSub;

   add16 adder_i (
      .a      (opA),
      .b      (opB),
      .ci     (cin),
      .sum    (sum),
      .co     (co),
      .pGroup (),     // Only needed when chaining wider adders
      .gGroup ()
   );

   always_comb begin
      case (op)
         ROL:     shMode = SH_ROL;
         SLL:     shMode = SH_SLL;
         ROR:     shMode = SH_ROR;
         default: shMode = SH_SRA;
      endcase
   end

   shift16 shifter_i (
      .in   (a),
      .cnt  (b[3:0]),
      .mode (shMode),
      .out  (shOut)
   );

   // Bit reverse for BTR
   always_comb begin
      for (int i = 0; i < dataW; i++)
         btrOut[i] = a[dataW-1-i];
   end

   assign eq = (a == b);
   assign lt = sign ? ($signed(a) < $signed(b)) : (a < b);

   always_comb begin
      case (op)
         ADD, SUB, ST, LD, STU, JR, JALR: result = sum;
         OR:                     result = a | b;
         AND:                    result = a & b;
         ROL, SLL, ROR, SRA:     result = shOut;
         BTR:                    result = btrOut;
         SEQ:                    result = dataW'(eq);
         SLT:                    result = dataW'(lt);
         SLE:                    result = dataW'(lt | eq);
         SCO:                    result = dataW'(co);
         SLBI:                   result = (a << 8) | {8'h00, b[7:0]};
         LBI, J, BEQZ, BNEZ, BLTZ: result = b;   // Immediate passes through
         default:                result = '0;
      endcase
   end

   assign sumOp = (op inside {ADD, SUB, ST, LD, STU, JR, JALR});

   // Same operand signs but the sum flipped
   assign oflSigned = (opA[dataW-1] == opB[dataW-1]) & (sum[dataW-1] != opA[dataW-1]);
   assign ofl       = sumOp & (sign ? oflSigned : co);

   assign zero = (result == '0) & (op == ADD || op == SUB);

endmodule

`default_nettype wire

//--- logic/branchResolve.sv
`timescale 1ns/10ps
`default_nettype none

module branchResolve import isaPkg::*; (
   input  aluOp_e           op,
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  logic [dataW-1:0] pc,
   input  logic [dataW-1:0] sum,
   output logic             redirect,
   output logic [dataW-1:0] target
);

   logic [dataW-1:0] pcNext;   // Fall-through address
   logic [dataW-1:0] pcRel;    // PC-relative target
   logic             aZero;

   assign pcNext = pc + dataW'(2);
   assign pcRel  = pcNext + b;
   assign aZero  = (a == '0);

   always_comb begin
      redirect = 1'b0;
      target   = pcNext;
      case (op)
         BEQZ: begin
            redirect = aZero;
            target   = pcRel;
         end
         BNEZ: begin
            redirect = !aZero;
            target   = pcRel;
         end
         BLTZ: begin
            redirect = a[dataW-1];   // Negative rs
            target   = pcRel;
         end
         J, JAL: begin
            redirect = 1'b1;
            target   = pcRel;
         end
         JR, JALR: begin
            redirect = 1'b1;
            target   = sum;          // rs + immediate from the ALU
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/execStage.sv
`timescale 1ns/10ps
`default_nettype none

module execStage import isaPkg::*, execPkg::*; (
   input  logic      clk,
   input  logic      arstN,
   input  logic      reqValid,
   input  execReq_t  req,
   output logic      respValid,
   output execResp_t resp
);

   logic [dataW-1:0] aluResult;
   logic [dataW-1:0] aluSum;
   logic             aluOfl;
   logic             aluZero;
   logic             redirect;
   logic [dataW-1:0] target;
   execResp_t        respNext;

   alu alu_i (
      .a      (req.a),
      .b      (req.b),
      .op     (req.op),
      .sign   (req.sign),
      .result (aluResult),
      .sum    (aluSum),
      .ofl    (aluOfl),
      .zero   (aluZero)
   );

   branchResolve branch_i (
      .op       (req.op),
      .a        (req.a),
      .b        (req.b),
      .pc       (req.pc),
      .sum      (aluSum),
      .redirect (redirect),
      .target   (target)
   );

   assign respNext = '{result: aluResult, ofl: aluOfl, zero: aluZero,
                       redirect: redirect, target: target};

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         respValid <= 1'b0;
         resp      <= '0;
      end else begin
         respValid <= reqValid;   // One pulse per strobe
         if (reqValid)
            resp <= respNext;     // Holds otherwise
      end
   end

endmodule

`default_nettype wire

//--- verif/execStageProps.sv
`timescale 1ns/10ps
`default_nettype none

module execStageProps (
   input logic clk,
   input logic arstN,
   input logic reqValid,
   input logic respValid,
   input logic redirect
);

   // Fixed latency of one cycle from strobe to result
   assert property (@(posedge clk) disable iff (!arstN) reqValid |=> respValid)
      else $error("respValid missing one cycle after reqValid");
   assert property (@(posedge clk) disable iff (!arstN) !reqValid |=> !respValid)
      else $error("respValid high without a strobe in the cycle before");

   assert property (@(posedge clk) !arstN |-> !respValid)
      else $error("respValid high during reset");

   assert property (@(posedge clk) disable iff (!arstN) $rose(redirect) |-> respValid)
      else $error("redirect rose without respValid");

endmodule

bind execStage execStageProps props_i (
   .clk       (clk),
   .arstN     (arstN),
   .reqValid  (reqValid),
   .respValid (respValid),
   .redirect  (resp.redirect)
);

`default_nettype wire

//--- verif/execStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module execStageTb import isaPkg::*, execPkg::*; ();

   logic      clk;
   logic      arstN;
   logic      reqValid;
   execReq_t  req;
   logic      respValid;
   execResp_t resp;
   int        seed = 93505;

   execStage execStage_i (
      .clk       (clk),
      .arstN     (arstN),
      .reqValid  (reqValid),
      .req       (req),
      .respValid (respValid),
      .resp      (resp)
   );

   always #5 clk = ~clk;   // 10 ns period

   // Expected response straight from the operation rules
   function automatic execResp_t model(input execReq_t r);
      execResp_t          e;
      logic [dataW-1:0]   x;
      logic [dataW-1:0]   y;
      logic [dataW:0]     s;
      logic [2*dataW-1:0] w;
      logic               lt;
      int                 n;
      e  = '0;
      x  = (r.op == SUB) ? r.b : r.a;    // SUB is b - a
      y  = (r.op == SUB) ? ~r.a : r.b;
      s  = {1'b0, x} + {1'b0, y} + (dataW+1)'(r.op == SUB);
      n  = r.b[3:0];
      lt = r.sign ? ($signed(r.a) < $signed(r.b)) : (r.a < r.b);
      case (r.op)
         ADD, SUB, ST, LD, STU, JR, JALR: begin
            e.result = s[dataW-1:0];
            e.ofl    = r.sign ? (x[dataW-1] == y[dataW-1] && s[dataW-1] != x[dataW-1])
                              : s[dataW];
         end
         OR:   e.result = r.a | r.b;
         AND:  e.result = r.a & r.b;
         SEQ:  e.result = dataW'(r.a == r.b);
         SLT:  e.result = dataW'(lt);
         SLE:  e.result = dataW'(lt || r.a == r.b);
         ROL: begin
            w        = {r.a, r.a} << n;
            e.result = w[2*dataW-1:dataW];
         end
         ROR: begin
            w        = {r.a, r.a} >> n;
            e.result = w[dataW-1:0];
         end
         SLL:  e.result = r.a << n;
         SRA:  e.result = $signed(r.a) >>> n;
         BTR: begin
            for (int i = 0; i < dataW; i++)
               e.result[i] = r.a[dataW-1-i];
         end
         SCO:  e.result = dataW'(s[dataW]);
         SLBI: e.result = {r.a[7:0], r.b[7:0]};
         LBI, J, BEQZ, BNEZ, BLTZ: e.result = r.b;
         default: ;
      endcase
      e.zero     = (e.result == '0) && (r.op == ADD || r.op == SUB);
      e.redirect = (r.op == BEQZ && r.a == '0) || (r.op == BNEZ && r.a != '0)
                 || (r.op == BLTZ && r.a[dataW-1]) || (r.op inside {J, JAL, JR, JALR});
      if (r.op inside {BEQZ, BNEZ, BLTZ, J, JAL})
         e.target = r.pc + 16'd2 + r.b;
      else if (r.op inside {JR, JALR})
         e.target = r.a + r.b;
      else
         e.target = r.pc + 16'd2;
      return e;
   endfunction

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check(input string what, input logic [dataW-1:0] got,
                        input logic [dataW-1:0] exp);
      if (got !== exp)
         abortRun($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic compareResp(input string tag, input execResp_t got, input execResp_t exp);
      check({tag, " result"}, got.result, exp.result);
      check({tag, " ofl"}, dataW'(got.ofl), dataW'(exp.ofl));
      check({tag, " zero"}, dataW'(got.zero), dataW'(exp.zero));
      check({tag, " redirect"}, dataW'(got.redirect), dataW'(exp.redirect));
      check({tag, " target"}, got.target, exp.target);
   endtask

   task automatic waitResp(input string tag);
      int n;
      n = 0;
      while (!respValid) begin
         if (n == 20)
            abortRun($sformatf("No respValid within 20 cycles for %s", tag));
         @(negedge clk);
         n++;
      end
   endtask

   // Single strobe, then wait for its result
   task automatic runReq(input aluOp_e op, input logic sign, input logic [dataW-1:0] a,
                         input logic [dataW-1:0] b, input logic [dataW-1:0] pc);
      execReq_t r;
      r = '{op: op, sign: sign, a: a, b: b, pc: pc};
      @(negedge clk);
      req      = r;
      reqValid = 1'b1;
      @(negedge clk);
      reqValid = 1'b0;
      waitResp(op.name());
      compareResp(op.name(), resp, model(r));
   endtask

   task automatic addSubTest();
      for (int s = 0; s < 2; s++) begin
         runReq(ADD, s[0], 16'h7fff, 16'h0001, '0);   // Signed overflow
         runReq(ADD, s[0], 16'hffff, 16'h0001, '0);   // Carry and zero
         runReq(ADD, s[0], 16'h1234, 16'h1111, '0);
         runReq(SUB, s[0], 16'h0001, 16'h8000, '0);
         runReq(SUB, s[0], 16'h0005, 16'h0005, '0);
         runReq(SUB, s[0], 16'h0010, 16'h0003, '0);
      end
   endtask

   task automatic logicCompareTest();
      runReq(OR, 1'b0, 16'ha5a5, 16'h0ff0, '0);
      runReq(AND, 1'b0, 16'ha5a5, 16'h0ff0, '0);
      for (int s = 0; s < 2; s++) begin
         runReq(SEQ, s[0], 16'h1234, 16'h1234, '0);
         runReq(SEQ, s[0], 16'h1234, 16'h1235, '0);
         runReq(SLT, s[0], 16'h8000, 16'h0001, '0);   // Order flips with sign
         runReq(SLT, s[0], 16'h0001, 16'h8000, '0);
         runReq(SLE, s[0], 16'h8000, 16'h0001, '0);
         runReq(SLE, s[0], 16'h1234, 16'h1234, '0);
      end
   endtask

   task automatic shiftTest();
      for (int n = 0; n < 16; n++) begin
         runReq(ROL, 1'b0, 16'h9a3c, dataW'(n), '0);
         runReq(SLL, 1'b0, 16'h9a3c, dataW'(n), '0);
         runReq(ROR, 1'b0, 16'h9a3c, dataW'(n), '0);
         runReq(SRA, 1'b0, 16'h9a3c, dataW'(n), '0);
      end
   endtask

   task automatic completedOpsTest();
      runReq(BTR, 1'b0, 16'h1234, '0, '0);
      runReq(SCO, 1'b0, 16'hffff, 16'h0001, '0);
      runReq(SCO, 1'b0, 16'h0001, 16'h0001, '0);
      runReq(SLBI, 1'b0, 16'h12ab, 16'h34cd, '0);
      runReq(LBI, 1'b0, 16'h0000, 16'hff80, '0);
      runReq(LD, 1'b0, 16'h2000, 16'h0010, '0);
      runReq(ST, 1'b0, 16'h2000, 16'hfffe, '0);
      runReq(STU, 1'b0, 16'h3000, 16'h0004, '0);
      runReq(HALT, 1'b0, 16'h5555, 16'haaaa, 16'h0100);
   endtask

   task automatic branchTest();
      runReq(BEQZ, 1'b0, 16'h0000, 16'hfff0, 16'h0100);
      runReq(BEQZ, 1'b0, 16'h0005, 16'hfff0, 16'h0100);
      runReq(BNEZ, 1'b0, 16'h0005, 16'h0020, 16'h0100);
      runReq(BNEZ, 1'b0, 16'h0000, 16'h0020, 16'h0100);
      runReq(BLTZ, 1'b0, 16'h8000, 16'h0040, 16'h0200);
      runReq(BLTZ, 1'b0, 16'h7fff, 16'h0040, 16'h0200);
      runReq(J, 1'b0, 16'h0000, 16'h0400, 16'h0300);
      runReq(JAL, 1'b0, 16'h0000, 16'hff00, 16'h0300);
      runReq(JR, 1'b0, 16'h4000, 16'h0008, 16'h0300);
      runReq(JALR, 1'b0, 16'h4000, 16'hfff8, 16'h0300);
   endtask

   // 200 strobes on consecutive cycles
   task automatic streamTest();
      execReq_t r;
      execReq_t sent[$];
      int       issued;
      issued = 0;
      while (issued < 200 || sent.size() > 0) begin
         @(negedge clk);
         if (respValid) begin
            if (sent.size() == 0)
               abortRun("respValid pulsed with no request outstanding");
            r = sent.pop_front();
            compareResp($sformatf("stream %s", r.op.name()), resp, model(r));
         end else if (issued > 0) begin
            abortRun("A back-to-back strobe got no respValid pulse");
         end
         if (issued < 200) begin
            r.op   = aluOp_e'(5'({$random(seed)} % 30));
            r.sign = 1'($random(seed));
            r.a    = 16'($random(seed));
            r.b    = 16'($random(seed));
            r.pc   = 16'($random(seed));
            req      = r;
            reqValid = 1'b1;
            sent.push_back(r);
            issued++;
         end else begin
            reqValid = 1'b0;
         end
      end
   endtask

   initial begin
      clk      = 1'b0;
      arstN    = 1'b0;
      reqValid = 1'b0;
      req      = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      check("reset respValid", dataW'(respValid), '0);   // Cleared state before any strobe
      compareResp("reset", resp, '0);
      addSubTest();
      logicCompareTest();
      shiftTest();
      completedOpsTest();
      branchTest();
      streamTest();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
logic/isaPkg.sv
logic/execPkg.sv
logic/add16.sv
logic/shift16.sv
logic/alu.sv
logic/branchResolve.sv
logic/execStage.sv
verif/execStageProps.sv
verif/execStageTb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - logic/isaPkg.sv
  - logic/execPkg.sv
  - logic/add16.sv
  - logic/shift16.sv
  - logic/alu.sv
  - logic/branchResolve.sv
  - logic/execStage.sv
  - target: test
    files:
      - verif/execStageProps.sv
      - verif/execStageTb.sv
